//--- src/rv32Pkg.sv
`default_nettype none

package rv32Pkg;

    // Datapath and storage sizes
    localparam int xlen        = 32;
    localparam int regCount    = 32;
    localparam int regAddrBits = 5;
    localparam int memWords    = 64;
    // Word index bits taken from the byte address above the lane bits
    localparam int memAddrBits = $clog2(memWords);

    // Major opcodes of the supported subset
    localparam logic [6:0] opOpImm = 7'b0010011;
    localparam logic [6:0] opOp    = 7'b0110011;
    localparam logic [6:0] opLui   = 7'b0110111;
    localparam logic [6:0] opJal   = 7'b1101111;
    localparam logic [6:0] opLoad  = 7'b0000011;
    localparam logic [6:0] opStore = 7'b0100011;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluSll,
        aluSlt,
        aluSltu,
        aluXor,
        aluSrl,
        aluSra,
        aluOr,
        aluAnd
    } aluOpE;

    // Write-back source
    typedef enum logic [1:0] {
        wbAlu,
        wbUpperImm,
        wbPcNext,
        wbMem
    } wbSelE;

    // Same encoding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        sizeByte = 2'b00,
        sizeHalf = 2'b01,
        sizeWord = 2'b10
    } memSizeE;

    typedef struct packed {
        logic                   regWrite;
        logic                   memWrite;
        logic                   memRead;
        logic                   rightFromReg;
        aluOpE                  aluOp;
        wbSelE                  wbSel;
        memSizeE                memSize;
        logic                   loadUnsigned;
        logic [regAddrBits-1:0] rd;
        logic [regAddrBits-1:0] rs1;
        logic [regAddrBits-1:0] rs2;
        logic [xlen-1:0]        imm;
    } ctrlT;

    // Register write reported by the core
    typedef struct packed {
        logic                   writeEnable;
        logic [regAddrBits-1:0] rd;
        logic [xlen-1:0]        data;
    } wbT;

endpackage

`default_nettype wire

//--- src/instrDecoder.sv
`timescale 1ns/1ns
`default_nettype none

module instrDecoder
    import rv32Pkg::*;
(
    input  wire [31:0] instruction,
    output ctrlT       ctrl
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            altBit;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;

    assign opcode = instruction[6:0];
    assign funct3 = instruction[14:12];
    // funct7 bit 30 picks SUB and the arithmetic shifts
    assign altBit = instruction[30];

    assign immI = {{20{instruction[31]}}, instruction[31:20]};
    assign immS = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};

    // SUB only exists in the register form
    function automatic aluOpE aluFromFunct(
        input logic [2:0] f3,
        input logic       alt,
        input logic       isReg
    );
        aluOpE op;
        case (f3)
            3'b000:  op = (isReg && alt) ? aluSub : aluAdd;
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b011:  op = aluSltu;
            3'b100:  op = aluXor;
            3'b101:  op = alt ? aluSra : aluSrl;
            3'b110:  op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl              = '0;
        ctrl.rd           = instruction[11:7];
        ctrl.rs1          = instruction[19:15];
        ctrl.rs2          = instruction[24:20];
        ctrl.aluOp        = aluAdd;
        ctrl.wbSel        = wbAlu;
        ctrl.memSize      = memSizeE'(funct3[1:0]);
        ctrl.loadUnsigned = funct3[2];

        case (opcode)
            opOpImm: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = aluFromFunct(funct3, altBit, 1'b0);
                ctrl.imm      = immI;
            end
            opOp: begin
                ctrl.regWrite     = 1'b1;
                ctrl.rightFromReg = 1'b1;
                ctrl.aluOp        = aluFromFunct(funct3, altBit, 1'b1);
            end
            opLui: begin
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = wbUpperImm;
            end
            opJal: begin
                // Link value only, the jump itself happens outside
                ctrl.regWrite = 1'b1;
                ctrl.wbSel    = wbPcNext;
            end
            opLoad: begin
                ctrl.regWrite = 1'b1;
                ctrl.memRead  = 1'b1;
                ctrl.wbSel    = wbMem;
                ctrl.imm      = immI;
            end
            opStore: begin
                ctrl.memWrite = 1'b1;
                ctrl.imm      = immS;
            end
            default: begin
                // Anything else falls through as a no-op
                ctrl.regWrite = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- src/regFile.sv
`timescale 1ns/1ns
`default_nettype none

module regFile
    import rv32Pkg::*;
(
    input  wire                   clk,
    input  wire                   rstN,
    input  wire [regAddrBits-1:0] rs1,
    input  wire [regAddrBits-1:0] rs2,
    input  wire [regAddrBits-1:0] rd,
    input  wire                   writeEnable,
    input  wire [xlen-1:0]        writeData,
    output logic [xlen-1:0]       rdDataA,
    output logic [xlen-1:0]       rdDataB
);

    logic [xlen-1:0] regs [regCount];

    // Write lands at the edge closing the cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && (rd != '0)) begin
            regs[rd] <= writeData;
        end
    end

    // x0 hardwired to zero
    assign rdDataA = (rs1 == '0) ? '0 : regs[rs1];
    assign rdDataB = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

//--- src/aluUnit.sv
`timescale 1ns/1ns
`default_nettype none

module aluUnit
    import rv32Pkg::*;
(
    input  wire aluOpE      op,
    input  wire [xlen-1:0]  left,
    input  wire [xlen-1:0]  right,
    output logic [xlen-1:0] result
);

    logic [4:0] shamt;

    // Only the low five bits count for shifts
    assign shamt = right[4:0];

    always_comb begin
        case (op)
            aluAdd:  result = left + right;
            aluSub:  result = left - right;
            aluSll:  result = left << shamt;
            aluSlt:  result = {{(xlen-1){1'b0}}, $signed(left) < $signed(right)};
            aluSltu: result = {{(xlen-1){1'b0}}, left < right};
            aluXor:  result = left ^ right;
            aluSrl:  result = left >> shamt;
            aluSra:  result = $unsigned($signed(left) >>> shamt);
            aluOr:   result = left | right;
            aluAnd:  result = left & right;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/dataMemory.sv
`timescale 1ns/1ns
`default_nettype none

module dataMemory
    import rv32Pkg::*;
(
    input  wire                   clk,
    input  wire                   rstN,
    input  wire [xlen-1:0]        address,
    input  wire                   writeEnable,
    input  wire memSizeE          size,
    input  wire                   loadUnsigned,
    input  wire [xlen-1:0]        writeData,
    output logic [xlen-1:0]       readData
);

    logic [xlen-1:0]        mem [memWords];
    logic [memAddrBits-1:0] wordIdx;
    logic [xlen-1:0]        curWord;
    logic [xlen-1:0]        mergedWord;
    logic [7:0]             byteLane;
    logic [15:0]            halfLane;

    // Low two bits only select lanes
    assign wordIdx = address[memAddrBits+1:2];
    assign curWord = mem[wordIdx];

    // Store merge, untouched lanes keep their old contents
    always_comb begin
        mergedWord = curWord;
        case (size)
            sizeByte: mergedWord[{address[1:0], 3'b000} +: 8] = writeData[7:0];
            sizeHalf: mergedWord[{address[1], 4'b0000} +: 16] = writeData[15:0];
            default:  mergedWord = writeData;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < memWords; i++) begin
                mem[i] <= '0;
            end
        end else if (writeEnable) begin
            mem[wordIdx] <= mergedWord;
        end
    end

    assign byteLane = curWord[{address[1:0], 3'b000} +: 8];
    assign halfLane = curWord[{address[1], 4'b0000} +: 16];

    // Load extract with sign or zero fill
    always_comb begin
        case (size)
            sizeByte: readData = {{24{byteLane[7] & ~loadUnsigned}}, byteLane};
            sizeHalf: readData = {{16{halfLane[15] & ~loadUnsigned}}, halfLane};
            default:  readData = curWord;
        endcase
    end

endmodule

`default_nettype wire

//--- src/singleCycleCore.sv
`timescale 1ns/1ns
`default_nettype none

module singleCycleCore
    import rv32Pkg::*;
(
    input  wire            clk,
    input  wire            rstN,
    input  wire [31:0]     instruction,
    input  wire [xlen-1:0] pcNext,
    output wbT             wb
);

    ctrlT            ctrl;
    logic [xlen-1:0] rdDataA;
    logic [xlen-1:0] rdDataB;
    logic [xlen-1:0] aluRight;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] memReadData;
    logic [xlen-1:0] loadData;
    logic [xlen-1:0] upperImm;
    logic [xlen-1:0] wbData;

    instrDecoder i_instrDecoder (
        .instruction (instruction),
        .ctrl        (ctrl)
    );

    regFile i_regFile (
        .clk         (clk),
        .rstN        (rstN),
        .rs1         (ctrl.rs1),
        .rs2         (ctrl.rs2),
        .rd          (wb.rd),
        .writeEnable (wb.writeEnable),
        .writeData   (wb.data),
        .rdDataA     (rdDataA),
        .rdDataB     (rdDataB)
    );

    // Register operand for OP, immediate for everything else
    assign aluRight = ctrl.rightFromReg ? rdDataB : ctrl.imm;

    aluUnit i_aluUnit (
        .op     (ctrl.aluOp),
        .left   (rdDataA),
        .right  (aluRight),
        .result (aluResult)
    );

    // ALU sum doubles as the byte address, rs2 is the store data
    dataMemory i_dataMemory (
        .clk          (clk),
        .rstN         (rstN),
        .address      (aluResult),
        .writeEnable  (ctrl.memWrite),
        .size         (ctrl.memSize),
        .loadUnsigned (ctrl.loadUnsigned),
        .writeData    (rdDataB),
        .readData     (memReadData)
    );

    assign loadData = ctrl.memRead ? memReadData : '0;
    assign upperImm = {instruction[31:12], 12'b0};

    always_comb begin
        case (ctrl.wbSel)
            wbUpperImm: wbData = upperImm;
            wbPcNext:   wbData = pcNext;
            wbMem:      wbData = loadData;
            default:    wbData = aluResult;
        endcase
    end

    // Write-back report, also the register write port
    always_comb begin
        wb.writeEnable = ctrl.regWrite;
        wb.rd          = ctrl.rd;
        wb.data        = wbData;
    end

endmodule

`default_nettype wire

//--- tb/singleCycleCore_props.sv
`timescale 1ns/1ns
`default_nettype none

module singleCycleCore_props
    import rv32Pkg::*;
(
    input wire       clk,
    input wire       rstN,
    input wire ctrlT ctrl,
    input wire wbT   wb
);

    // Number of failed assertions
    int failCount = 0;

    // A store never also writes a register
    storeNoRegWrite: assert property (@(posedge clk) !(ctrl.memWrite && ctrl.regWrite))
        else begin
            failCount++;
            $error("store decoded together with a register write");
        end

    wbDataKnown: assert property (@(posedge clk) disable iff (!rstN)
        wb.writeEnable |-> !$isunknown(wb.data))
        else begin
            failCount++;
            $error("write-back data unknown during a register write");
        end

    noWriteInReset: assert property (@(posedge clk) !rstN |-> !wb.writeEnable)
        else begin
            failCount++;
            $error("register write reported while in reset");
        end

endmodule

`default_nettype wire

//--- tb/coreTb.sv
`timescale 1ns/1ns
`default_nettype none

module coreTb
    import rv32Pkg::*;
();

    localparam int resetCycles = 16;
    localparam int randomCount = 2000;
    // Reset, at most 64 directed instructions, the random run and some slack
    localparam int maxCycles   = resetCycles + 64 + randomCount + 20;

    logic        clk;
    logic        rstN;
    logic [31:0] instruction;
    logic [31:0] pcNext;
    wbT          wb;

    logic [31:0] lfsrState      = 32'hbe49;
    logic [31:0] modelRegs [32] = '{default: '0};
    logic [7:0]  modelMem [256] = '{default: '0};
    int          cycleCount     = 0;

    singleCycleCore i_singleCycleCore (
        .clk         (clk),
        .rstN        (rstN),
        .instruction (instruction),
        .pcNext      (pcNext),
        .wb          (wb)
    );

    bind singleCycleCore singleCycleCore_props i_props (
        .clk  (clk),
        .rstN (rstN),
        .ctrl (ctrl),
        .wb   (wb)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] randBits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'hd0000001) : (lfsrState >> 1);
            value     = {value[30:0], lfsrState[0]};
        end
        return value;
    endfunction

    function automatic logic [31:0] iType(input logic [6:0] op, input logic [2:0] f3,
                                          input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    // Expected report from the ISA rules and the model state
    function automatic wbT predictWb(input logic [31:0] instr, input logic [31:0] pcn);
        wbT          expected;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] immI;
        logic [4:0]  sh;
        logic [7:0]  addr;
        logic [15:0] half;
        expected    = '0;
        expected.rd = instr[11:7];
        a    = modelRegs[instr[19:15]];
        immI = {{20{instr[31]}}, instr[31:20]};
        b    = (instr[6:0] == opOp) ? modelRegs[instr[24:20]] : immI;
        sh   = b[4:0];
        addr = 8'(a + immI);
        half = {modelMem[{addr[7:1], 1'b1}], modelMem[{addr[7:1], 1'b0}]};
        expected.writeEnable = (instr[6:0] inside {opOpImm, opOp, opLui, opJal, opLoad});
        case (instr[6:0])
            opOpImm, opOp: begin
                case (instr[14:12])
                    3'b000: expected.data = (instr[6:0] == opOp && instr[30]) ? a - b : a + b;
                    3'b001: expected.data = a << sh;
                    3'b010: expected.data = {31'b0, $signed(a) < $signed(b)};
                    3'b011: expected.data = {31'b0, a < b};
                    3'b100: expected.data = a ^ b;
                    // Arithmetic form refills the top with bit 31
                    3'b101: expected.data = (a >> sh) |
                                            ((instr[30] && a[31]) ? ~(32'hffffffff >> sh) : '0);
                    3'b110: expected.data = a | b;
                    default: expected.data = a & b;
                endcase
            end
            opLui: expected.data = {instr[31:12], 12'b0};
            opJal: expected.data = pcn;
            opLoad: begin
                case (instr[14:12])
                    3'b000: expected.data = {{24{modelMem[addr][7]}}, modelMem[addr]};
                    3'b100: expected.data = {24'b0, modelMem[addr]};
                    3'b001: expected.data = {{16{half[15]}}, half};
                    3'b101: expected.data = {16'b0, half};
                    default: expected.data = {modelMem[{addr[7:2], 2'd3}],
                                              modelMem[{addr[7:2], 2'd2}],
                                              modelMem[{addr[7:2], 2'd1}],
                                              modelMem[{addr[7:2], 2'd0}]};
                endcase
            end
            default: expected.data = '0;
        endcase
        return expected;
    endfunction

    task automatic commitModel(input logic [31:0] instr, input wbT expected);
        logic [7:0]  addr;
        logic [31:0] data;
        int          laneLo;
        int          laneCount;
        addr = 8'(modelRegs[instr[19:15]] + {{20{instr[31]}}, instr[31:25], instr[11:7]});
        data = modelRegs[instr[24:20]];
        if (expected.writeEnable && expected.rd != 5'd0) begin
            modelRegs[expected.rd] = expected.data;
        end
        if (instr[6:0] == opStore) begin
            // Lanes covered by the access with the low address bits dropped
            case (instr[13:12])
                2'b00: begin
                    laneLo    = int'(addr[1:0]);
                    laneCount = 1;
                end
                2'b01: begin
                    laneLo    = 2 * int'(addr[1]);
                    laneCount = 2;
                end
                default: begin
                    laneLo    = 0;
                    laneCount = 4;
                end
            endcase
            // Lowest data byte goes to the lowest lane
            for (int k = laneLo; k < laneLo + laneCount; k++) begin
                modelMem[{addr[7:2], 2'(k)}] = data[8 * (k - laneLo) +: 8];
            end
        end
    endtask

    task automatic compareWb(input wbT actual, input wbT expected);
        // rd and data only matter when a write is expected
        if (actual.writeEnable !== expected.writeEnable ||
            (expected.writeEnable && actual !== expected)) begin
            $display("FAIL %0t wb: got we=%b rd=%0d data=%h, expected we=%b rd=%0d data=%h",
                     $time, actual.writeEnable, actual.rd, actual.data,
                     expected.writeEnable, expected.rd, expected.data);
            $display("SOME TESTS FAILED");
            $fatal(1, "wb mismatch");
        end
    endtask

    task automatic runInstr(input logic [31:0] instr, input logic [31:0] pcn);
        wbT expected;
        @(posedge clk);
        instruction <= instr;
        pcNext      <= pcn;
        @(negedge clk);
        expected = predictWb(instr, pcn);
        compareWb(wb, expected);
        commitModel(instr, expected);
    endtask

    function automatic logic [31:0] randomInstr();
        logic [2:0]  grp;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [1:0]  sel;
        logic [11:0] imm;
        grp = 3'(randBits(3));
        f3  = 3'(randBits(3));
        rd  = 5'(randBits(5) % 29);
        rs1 = 5'(randBits(5));
        rs2 = 5'(randBits(5));
        imm = 12'(randBits(12));
        sel = 2'(randBits(2));
        // Base is x0 with a byte offset, or x29..x31 with a short offset
        if (grp == 3'd4 || grp == 3'd5) begin
            rs1 = (sel == 2'd0) ? 5'd0 : 5'd28 + 5'(sel);
            imm = (sel == 2'd0) ? 12'(randBits(8)) : 12'(int'(randBits(6)) - 16);
        end
        case (grp)
            3'd0: begin
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    imm = {1'b0, imm[10] & f3[2], 5'b0, imm[4:0]};
                end
                return {imm, rs1, f3, rd, opOpImm};
            end
            3'd1: return {1'b0, imm[0] && (f3 == 3'b000 || f3 == 3'b101), 5'b0,
                          rs2, rs1, f3, rd, opOp};
            3'd2: return {imm, rs1, f3, rd, opLui};
            3'd3: return {imm, rs1, f3, rd, opJal};
            3'd4: return {imm, rs1, (f3 inside {3'b011, 3'b110, 3'b111}) ? 3'b010 : f3, rd, opLoad};
            3'd5: return {imm[11:5], rs2, rs1, 1'b0, (f3[1:0] == 2'b11) ? 2'b00 : f3[1:0],
                          imm[4:0], opStore};
            // Branch opcode is outside the subset
            default: return {imm, rs1, f3, rd, 7'b1100011};
        endcase
    endfunction

    initial begin
        logic [31:0] instr;
        logic [31:0] pcn;
        rstN        <= 1'b0;
        instruction <= '0;
        pcNext      <= '0;
        repeat (resetCycles - 1) @(posedge clk);
        @(negedge clk);
        compareWb(wb, '0);
        @(posedge clk);
        rstN <= 1'b1;

        // Reads after reset go to x0 and leave the state clear
        for (int r = 0; r < regCount; r++) begin
            runInstr(iType(opOpImm, 3'b000, 5'd0, 5'(r), 12'd0), '0);
        end
        runInstr(iType(opOpImm, 3'b000, 5'd29, 5'd0, 12'd16), '0);
        runInstr(iType(opOpImm, 3'b000, 5'd30, 5'd0, 12'd112), '0);
        runInstr(iType(opOpImm, 3'b000, 5'd31, 5'd0, 12'd208), '0);
        // Operands f0f0f0f0, -7 and 3
        runInstr({20'hf0f0f, 5'd1, opLui}, '0);
        runInstr(iType(opOpImm, 3'b000, 5'd1, 5'd1, 12'h0f0), '0);
        runInstr(iType(opOpImm, 3'b000, 5'd2, 5'd0, 12'(-7)), '0);
        runInstr(iType(opOpImm, 3'b000, 5'd3, 5'd0, 12'd3), '0);
        runInstr({7'b0100000, 5'd2, 5'd3, 3'b000, 5'd4, opOp}, '0);
        runInstr({7'b0100000, 5'd3, 5'd1, 3'b101, 5'd5, opOp}, '0);
        runInstr({7'b0000000, 5'd3, 5'd1, 3'b101, 5'd6, opOp}, '0);
        runInstr(iType(opOpImm, 3'b101, 5'd7, 5'd1, 12'h404), '0);
        runInstr({7'b0, 5'd3, 5'd2, 3'b010, 5'd8, opOp}, '0);
        runInstr({7'b0, 5'd3, 5'd2, 3'b011, 5'd9, opOp}, '0);
        runInstr(iType(opOpImm, 3'b010, 5'd10, 5'd2, 12'(-1)), '0);
        runInstr(iType(opOpImm, 3'b011, 5'd11, 5'd3, 12'(-1)), '0);
        runInstr({20'h12345, 5'd12, opJal}, 32'h0000_1234);
        // Word, byte and halfword stores followed by every load form
        runInstr({7'd0, 5'd1, 5'd30, 3'b010, 5'd0, opStore}, '0);
        runInstr({7'd0, 5'd3, 5'd30, 3'b000, 5'd1, opStore}, '0);
        runInstr({7'd0, 5'd2, 5'd30, 3'b001, 5'd6, opStore}, '0);
        runInstr(iType(opLoad, 3'b000, 5'd13, 5'd30, 12'd1), '0);
        runInstr(iType(opLoad, 3'b100, 5'd14, 5'd30, 12'd3), '0);
        runInstr(iType(opLoad, 3'b001, 5'd15, 5'd30, 12'd2), '0);
        runInstr(iType(opLoad, 3'b101, 5'd16, 5'd30, 12'd6), '0);
        runInstr(iType(opLoad, 3'b010, 5'd17, 5'd30, 12'd0), '0);
        runInstr(iType(opLoad, 3'b010, 5'd18, 5'd30, 12'd4), '0);
        runInstr(iType(opLoad, 3'b001, 5'd19, 5'd30, 12'd7), '0);
        // x0 write is reported but does not stick
        runInstr(iType(opOpImm, 3'b000, 5'd0, 5'd1, 12'd0), '0);
        runInstr(iType(opOpImm, 3'b000, 5'd20, 5'd0, 12'd0), '0);

        for (int n = 0; n < randomCount; n++) begin
            instr = randomInstr();
            pcn   = randBits(32);
            runInstr(instr, pcn);
        end

        if (i_singleCycleCore.i_props.failCount == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("Assertion failures during the run: %0d",
                     i_singleCycleCore.i_props.failCount);
            $display("SOME TESTS FAILED");
            $fatal(1, "run ended with assertion failures");
        end
    end

    initial begin
        while (cycleCount < maxCycles) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: run did not finish within %0d cycles", maxCycles);
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

//--- build.f
src/rv32Pkg.sv
src/instrDecoder.sv
src/regFile.sv
src/aluUnit.sv
src/dataMemory.sv
src/singleCycleCore.sv
tb/singleCycleCore_props.sv
tb/coreTb.sv

//--- Makefile
TOP = coreTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -Mdir obj_dir

run: compile
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
